// File: tb.f
source/alu_pkg.sv
source/float_pkg.sv
source/int_to_float.sv
source/float_to_int.sv
source/float_compare.sv
source/float_add_sub.sv
source/float_multiply.sv
source/float_unit.sv
dv/float_unit_tb.sv

// File: dv/float_unit_tb.sv
`timescale 1ns/1ns

module float_unit_tb;
  import alu_pkg::*;
  import float_pkg::*;

  localparam int RANDOM_VECTORS = 60;
  localparam int TOTAL_VECTORS = RANDOM_VECTORS + 20;
  localparam int WATCHDOG_CYCLES = TOTAL_VECTORS * 40 + 200;

  logic               clk;
  logic               rst;
  alu_op_t            alu_op;
  logic [FLOAT_W-1:0] left_operand;
  logic [FLOAT_W-1:0] right_operand;
  logic [FLOAT_W-1:0] int_float_res;
  logic               int_float_busy;
  logic [FLOAT_W-1:0] float_int_res;
  logic [FLOAT_W-1:0] float_add_res;
  logic [FLOAT_W-1:0] float_sub_res;
  logic               float_lt_res;
  logic               float_lte_res;
  logic [FLOAT_W-1:0] float_mul_res;

  // Expected values travel with the operands
  logic               cmp_ok;
  logic               cvt_ok;
  logic               arith_ok;
  logic               exp_lt;
  logic               exp_lte;
  logic [FLOAT_W-1:0] exp_int;
  logic [FLOAT_W-1:0] exp_add;
  logic [FLOAT_W-1:0] exp_sub;
  logic [FLOAT_W-1:0] exp_mul;
  logic [FLOAT_W-1:0] conv_expected;
  int                 busy_len;
  logic [31:0]        seed;
  int                 errors;
  int                 vectors;
  int                 conversions;

  float_unit dut (
    .clk           (clk),
    .rst           (rst),
    .alu_op        (alu_op),
    .left_operand  (left_operand),
    .right_operand (right_operand),
    .int_float_res (int_float_res),
    .int_float_busy(int_float_busy),
    .float_int_res (float_int_res),
    .float_add_res (float_add_res),
    .float_sub_res (float_sub_res),
    .float_lt_res  (float_lt_res),
    .float_lte_res (float_lte_res),
    .float_mul_res (float_mul_res)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // Exact for small magnitudes, truncated above 24 bits
  function automatic logic [FLOAT_W-1:0] to_float(input int v);
    logic [31:0] mag;
    logic [31:0] mant;
    int          top;
    if (v == 0) return '0;
    mag = (v < 0) ? -v : v;
    top = 31;
    while (!mag[top]) top--;
    if (top > MANT_W) mant = mag >> (top - MANT_W);
    else mant = mag << (MANT_W - top);
    return {v < 0, EXP_W'(top + EXP_BIAS), mant[MANT_W-1:0]};
  endfunction

  function automatic logic [FLOAT_W-1:0] scale_down(input logic [FLOAT_W-1:0] w, input int k);
    return {w[FLOAT_W-1], w[FLOAT_W-2:MANT_W] - EXP_W'(k), w[MANT_W-1:0]};  // Divide by 2^k
  endfunction

  task automatic count_error(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic apply_words(input logic [FLOAT_W-1:0] lw, input logic [FLOAT_W-1:0] rw,
                             input int a, input int b);
    @(posedge clk);
    #1;
    left_operand  = lw;
    right_operand = rw;
    exp_lt   = a < b;
    exp_lte  = a <= b;
    exp_int  = a;
    exp_add  = to_float(a + b);
    exp_sub  = to_float(a - b);
    exp_mul  = to_float(a * b);
    cmp_ok   = 1'b1;
    cvt_ok   = 1'b1;
    arith_ok = 1'b1;
    vectors++;
  endtask

  task automatic apply_pair(input int a, input int b);
    apply_words(to_float(a), to_float(b), a, b);
  endtask

  task automatic apply_fraction(input int n, input int k);
    @(posedge clk);
    #1;
    left_operand  = scale_down(to_float(n), k);
    right_operand = '0;
    exp_int  = n / (1 << k);  // Truncates toward zero
    cmp_ok   = 1'b0;
    cvt_ok   = 1'b1;
    arith_ok = 1'b0;
    vectors++;
  endtask

  task automatic run_conversion(input int v, input bit extra_request);
    int waited;
    @(posedge clk);
    #1;
    cmp_ok        = 1'b0;
    cvt_ok        = 1'b0;
    arith_ok      = 1'b0;
    alu_op        = ALU_F_INT_FLOAT;
    left_operand  = v;
    conv_expected = to_float(v);
    @(posedge clk);
    #1;
    if (!int_float_busy) count_error("int_float_busy did not rise after a start");
    if (extra_request) begin
      left_operand = 32'h0000_7777;  // Must not restart
      repeat (3) @(posedge clk);
      #1;
    end
    alu_op = ALU_NOP;
    waited = 0;
    while (int_float_busy && waited < 40) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (int_float_busy) begin
      errors++;
      $display("Conversion never finished, int_float_busy stayed high for 40 cycles");
    end
    conversions++;
  endtask

  always @(posedge clk) begin
    if (rst || !int_float_busy) busy_len <= 0;
    else busy_len <= busy_len + 1;
  end

  reset_state: assert property (@(posedge clk)
    $fell(rst) |-> (!int_float_busy && int_float_res == '0))
    else count_error("int_float_busy or int_float_res not cleared by reset");

  compare_now: assert property (@(posedge clk) disable iff (rst)
    cmp_ok |-> (float_lt_res == exp_lt && float_lte_res == exp_lte))
    else count_error($sformatf("compare lt %b lte %b", float_lt_res, float_lte_res));

  to_int_one_cycle: assert property (@(posedge clk) disable iff (rst)
    $past(cvt_ok) |-> float_int_res == $past(exp_int))
    else count_error($sformatf("float_int_res %h wrong", float_int_res));

  add_sub_two_cycles: assert property (@(posedge clk) disable iff (rst)
    $past(arith_ok, 2) |-> (float_add_res == $past(exp_add, 2) &&
                            float_sub_res == $past(exp_sub, 2)))
    else count_error($sformatf("sum %h difference %h wrong", float_add_res, float_sub_res));

  mul_two_cycles: assert property (@(posedge clk) disable iff (rst)
    $past(arith_ok, 2) |-> float_mul_res == $past(exp_mul, 2))
    else count_error($sformatf("float_mul_res %h wrong", float_mul_res));

  busy_exact: assert property (@(posedge clk) disable iff (rst)
    $fell(int_float_busy) |-> busy_len == INT_FLOAT_CYCLES)
    else count_error($sformatf("int_float_busy lasted %0d cycles", busy_len));

  conv_result: assert property (@(posedge clk) disable iff (rst)
    $fell(int_float_busy) |-> int_float_res == conv_expected)
    else count_error($sformatf("int_float_res %h, expected %h", int_float_res, conv_expected));

  conv_hold: assert property (@(posedge clk) disable iff (rst)
    (!int_float_busy && $past(!int_float_busy)) |-> $stable(int_float_res))
    else count_error("int_float_res changed while idle");

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    int a;
    int b;
    logic [31:0] r;
    clk = 1'b0;
    rst = 1'b1;
    alu_op = ALU_NOP;
    left_operand = '0;
    right_operand = '0;
    {cmp_ok, cvt_ok, arith_ok, exp_lt, exp_lte} = '0;
    {exp_int, exp_add, exp_sub, exp_mul, conv_expected} = '0;
    seed = 32'he230;
    errors = 0;
    vectors = 0;
    conversions = 0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    apply_pair(5, 3);  // All four sign combinations
    apply_pair(-5, 3);
    apply_pair(5, -3);
    apply_pair(-5, -3);
    apply_pair(7, 7);
    apply_pair(0, 9);
    apply_pair(-12, 0);
    apply_words(32'h8000_0000, 32'h0000_0000, 0, 0);  // -0 against +0
    apply_words(32'h0000_0000, 32'h8000_0000, 0, 0);
    for (int i = 0; i < RANDOM_VECTORS; i++) begin
      r = lcg_next();
      a = int'((r >> 8) & 32'hfff);
      if (r[31]) a = -a;
      r = lcg_next();
      b = int'((r >> 8) & 32'hfff);
      if (r[31]) b = -b;
      apply_pair(a, b);
    end
    apply_fraction(7, 2);
    apply_fraction(-7, 2);
    apply_fraction(3, 2);
    apply_fraction(-1, 1);
    apply_fraction(100, 3);
    run_conversion(1234, 1'b0);
    run_conversion(-1234, 1'b0);
    run_conversion(0, 1'b0);
    run_conversion(32'h1234_5678, 1'b0);  // Truncated mantissa
    run_conversion(-5, 1'b1);
    repeat (4) @(posedge clk);
    $display("Vectors %0d, conversions %0d, errors %0d", vectors, conversions, errors);
    if (errors == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

endmodule

// File: source/float_unit.sv
`timescale 1ns/1ns

module float_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  alu_pkg::alu_op_t              alu_op,
  input  logic [float_pkg::FLOAT_W-1:0] left_operand,
  input  logic [float_pkg::FLOAT_W-1:0] right_operand,
  output logic [float_pkg::FLOAT_W-1:0] int_float_res,
  output logic                          int_float_busy,
  output logic [float_pkg::FLOAT_W-1:0] float_int_res,
  output logic [float_pkg::FLOAT_W-1:0] float_add_res,
  output logic [float_pkg::FLOAT_W-1:0] float_sub_res,
  output logic                          float_lt_res,
  output logic                          float_lte_res,
  output logic [float_pkg::FLOAT_W-1:0] float_mul_res
);

  int_to_float u_int_to_float (
    .clk           (clk),
    .rst           (rst),
    .alu_op        (alu_op),
    .left_operand  (left_operand),
    .int_float_res (int_float_res),
    .int_float_busy(int_float_busy)
  );

  float_to_int u_float_to_int (
    .clk          (clk),
    .left_operand (left_operand),
    .float_int_res(float_int_res)
  );

  float_compare u_float_compare (
    .left_operand (left_operand),
    .right_operand(right_operand),
    .float_lt_res (float_lt_res),
    .float_lte_res(float_lte_res)
  );

  float_add_sub u_float_add_sub (
    .clk          (clk),
    .left_operand (left_operand),
    .right_operand(right_operand),
    .float_add_res(float_add_res),
    .float_sub_res(float_sub_res)
  );

  float_multiply u_float_multiply (
    .clk          (clk),
    .left_operand (left_operand),
    .right_operand(right_operand),
    .float_mul_res(float_mul_res)
  );

endmodule

// File: source/float_multiply.sv
`timescale 1ns/1ns

module float_multiply (
  input  logic                          clk,
  input  logic [float_pkg::FLOAT_W-1:0] left_operand,
  input  logic [float_pkg::FLOAT_W-1:0] right_operand,
  output logic [float_pkg::FLOAT_W-1:0] float_mul_res
);
  import float_pkg::*;

  float_word_t         l_w;
  float_word_t         r_w;
  logic [2*MANT_W+1:0] prod_q;
  logic [EXP_W-1:0]    exp_q;
  logic                sign_q;
  logic                zero_q;
  float_word_t         mul_w;

  assign l_w.raw = left_operand;
  assign r_w.raw = right_operand;

  always_ff @(posedge clk) begin
    prod_q <= {1'b1, l_w.f.mant} * {1'b1, r_w.f.mant};
    exp_q  <= EXP_W'(l_w.f.exp + r_w.f.exp - EXP_BIAS);
    sign_q <= l_w.f.sign ^ r_w.f.sign;
    zero_q <= (l_w.f.exp == '0) || (r_w.f.exp == '0);
  end

  always_comb begin
    mul_w.raw = '0;
    if (!zero_q) begin
      mul_w.f.sign = sign_q;
      if (prod_q[2*MANT_W+1]) begin
        mul_w.f.exp  = exp_q + 1'b1;  // Product in [2,4)
        mul_w.f.mant = prod_q[2*MANT_W:MANT_W+1];
      end else begin
        mul_w.f.exp  = exp_q;
        mul_w.f.mant = prod_q[2*MANT_W-1:MANT_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    float_mul_res <= mul_w.raw;
  end

endmodule

// File: source/float_add_sub.sv
`timescale 1ns/1ns

module float_add_sub (
  input  logic                          clk,
  input  logic [float_pkg::FLOAT_W-1:0] left_operand,
  input  logic [float_pkg::FLOAT_W-1:0] right_operand,
  output logic [float_pkg::FLOAT_W-1:0] float_add_res,
  output logic [float_pkg::FLOAT_W-1:0] float_sub_res
);
  import float_pkg::*;

  float_word_t       l_w;
  float_word_t       r_w;
  logic              left_big;
  logic [EXP_W-1:0]  exp_diff;
  logic [MANT_W:0]   l_mant;
  logic [MANT_W:0]   r_mant;

  // Stage one registers
  logic [MANT_W:0]   big_q;
  logic [MANT_W:0]   small_q;
  logic [EXP_W-1:0]  exp_q;
  logic              l_sign_q;
  logic              r_sign_q;
  logic              left_big_q;

  logic [MANT_W+1:0] sum;
  logic [MANT_W:0]   diff;
  logic [MANT_W:0]   diff_norm;
  logic [EXP_W-1:0]  lz;
  float_word_t       sum_w;
  float_word_t       diff_w;
  float_word_t       add_w;
  float_word_t       sub_w;

  assign l_w.raw = left_operand;
  assign r_w.raw = right_operand;

  assign left_big = l_w.raw[FLOAT_W-2:0] >= r_w.raw[FLOAT_W-2:0];
  assign l_mant   = {l_w.f.exp != '0, l_w.f.mant};  // Zero has no hidden bit
  assign r_mant   = {r_w.f.exp != '0, r_w.f.mant};
  assign exp_diff = left_big ? l_w.f.exp - r_w.f.exp : r_w.f.exp - l_w.f.exp;

  always_ff @(posedge clk) begin
    if (left_big) begin
      big_q   <= l_mant;
      small_q <= r_mant >> exp_diff;
      exp_q   <= l_w.f.exp;
    end else begin
      big_q   <= r_mant;
      small_q <= l_mant >> exp_diff;
      exp_q   <= r_w.f.exp;
    end
    l_sign_q   <= l_w.f.sign;
    r_sign_q   <= r_w.f.sign;
    left_big_q <= left_big;
  end

  assign sum  = {1'b0, big_q} + {1'b0, small_q};
  assign diff = big_q - small_q;  // Never negative

  always_comb begin
    sum_w.raw = '0;
    if (sum[MANT_W+1]) begin
      sum_w.f.exp  = exp_q + 1'b1;  // Carry out
      sum_w.f.mant = sum[MANT_W:1];
    end else if (sum[MANT_W]) begin
      sum_w.f.exp  = exp_q;
      sum_w.f.mant = sum[MANT_W-1:0];
    end
  end

  always_comb begin
    lz = EXP_W'(MANT_W + 1);
    for (int i = 0; i <= MANT_W; i++) begin
      if (diff[i]) begin
        lz = EXP_W'(MANT_W - i);
      end
    end
  end

  assign diff_norm = diff << lz;

  always_comb begin
    diff_w.raw = '0;
    if (diff != '0) begin
      diff_w.f.exp  = exp_q - lz;
      diff_w.f.mant = diff_norm[MANT_W-1:0];
    end
  end

  // Sum when effective signs agree, else difference with the larger sign
  always_comb begin
    add_w = (l_sign_q == r_sign_q) ? sum_w : diff_w;
    sub_w = (l_sign_q != r_sign_q) ? sum_w : diff_w;
    if (add_w.raw[FLOAT_W-2:0] != '0) begin
      add_w.f.sign = left_big_q ? l_sign_q : r_sign_q;
    end
    if (sub_w.raw[FLOAT_W-2:0] != '0) begin
      sub_w.f.sign = left_big_q ? l_sign_q : ~r_sign_q;
    end
  end

  always_ff @(posedge clk) begin
    float_add_res <= add_w.raw;
    float_sub_res <= sub_w.raw;
  end

  aligned_hidden_bit: assert property (@(posedge clk)
    (exp_q != '0) |-> (big_q[MANT_W] && (small_q <= big_q)));

endmodule

// File: source/float_compare.sv
`timescale 1ns/1ns

module float_compare (
  input  logic [float_pkg::FLOAT_W-1:0] left_operand,
  input  logic [float_pkg::FLOAT_W-1:0] right_operand,
  output logic                          float_lt_res,
  output logic                          float_lte_res
);
  import float_pkg::*;

  float_word_t        l_w;
  float_word_t        r_w;
  logic [FLOAT_W-2:0] l_mag;
  logic [FLOAT_W-2:0] r_mag;
  logic               both_zero;

  assign l_w.raw   = left_operand;
  assign r_w.raw   = right_operand;
  assign l_mag     = {l_w.f.exp, l_w.f.mant};
  assign r_mag     = {r_w.f.exp, r_w.f.mant};
  assign both_zero = (l_mag == '0) && (r_mag == '0);

  always_comb begin
    if (both_zero) begin
      float_lt_res  = 1'b0;  // +0 equals -0
      float_lte_res = 1'b1;
    end else if (l_w.f.sign != r_w.f.sign) begin
      float_lt_res  = l_w.f.sign;
      float_lte_res = l_w.f.sign;
    end else if (l_w.f.sign) begin
      float_lt_res  = r_mag < l_mag;  // Both negative
      float_lte_res = r_mag <= l_mag;
    end else begin
      float_lt_res  = l_mag < r_mag;
      float_lte_res = l_mag <= r_mag;
    end
  end

endmodule

// File: source/float_to_int.sv
`timescale 1ns/1ns

module float_to_int (
  input  logic                          clk,
  input  logic [float_pkg::FLOAT_W-1:0] left_operand,
  output logic [float_pkg::FLOAT_W-1:0] float_int_res
);
  import float_pkg::*;

  float_word_t        l_w;
  logic [EXP_W-1:0]   unbiased;
  logic [FLOAT_W-1:0] mag;

  assign l_w.raw = left_operand;

  assign unbiased = EXP_W'(l_w.f.exp - EXP_BIAS);

  // Whole part of the hidden-bit mantissa
  assign mag = {{(FLOAT_W-MANT_W-1){1'b0}}, 1'b1, l_w.f.mant} >> (MANT_W - int'(unbiased));

  always_ff @(posedge clk) begin
    if (l_w.f.exp < EXP_BIAS) begin
      float_int_res <= '0;  // Magnitude below one
    end else if (l_w.f.sign) begin
      float_int_res <= -mag;
    end else begin
      float_int_res <= mag;
    end
  end

endmodule

// File: source/int_to_float.sv
`timescale 1ns/1ns

module int_to_float (
  input  logic                         clk,
  input  logic                         rst,
  input  alu_pkg::alu_op_t             alu_op,
  input  logic [float_pkg::FLOAT_W-1:0] left_operand,
  output logic [float_pkg::FLOAT_W-1:0] int_float_res,
  output logic                         int_float_busy
);
  import alu_pkg::*;
  import float_pkg::*;

  logic                       start;
  logic [INT_FLOAT_CNT_W-1:0] cnt;
  logic                       sign_q;
  logic [FLOAT_W-1:0]         mag_q;
  logic [FLOAT_W-1:0]         shift_q;
  logic [INT_FLOAT_CNT_W-1:0] lead_q;
  logic                       found_q;
  logic [INT_FLOAT_CNT_W-1:0] lead_next;
  logic                       found_next;
  logic [FLOAT_W+MANT_W-1:0]  mant_long;
  float_word_t                res_next;
  float_word_t                res_q;

  assign start = (alu_op == ALU_F_INT_FLOAT) && !int_float_busy;

  assign lead_next  = shift_q[0] ? cnt : lead_q;  // Highest set bit so far
  assign found_next = found_q | shift_q[0];
  assign mant_long  = {mag_q, MANT_W'(0)} >> lead_next;

  always_comb begin
    res_next.raw    = '0;
    res_next.f.sign = sign_q;
    res_next.f.exp  = EXP_W'(lead_next + EXP_BIAS);
    res_next.f.mant = mant_long[MANT_W-1:0];  // Bits below leading one
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      int_float_busy <= 1'b0;
      cnt            <= '0;
      res_q.raw      <= '0;
    end else if (start) begin
      int_float_busy <= 1'b1;
      cnt            <= '0;
    end else if (int_float_busy) begin
      if (cnt == INT_FLOAT_CNT_W'(INT_FLOAT_CYCLES - 1)) begin
        int_float_busy <= 1'b0;
        res_q.raw      <= found_next ? res_next.raw : '0;  // Zero input
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sign_q  <= left_operand[FLOAT_W-1];
      mag_q   <= left_operand[FLOAT_W-1] ? -left_operand : left_operand;
      shift_q <= left_operand[FLOAT_W-1] ? -left_operand : left_operand;
      lead_q  <= '0;
      found_q <= 1'b0;
    end else if (int_float_busy) begin
      shift_q <= shift_q >> 1;
      lead_q  <= lead_next;
      found_q <= found_next;
    end
  end

  assign int_float_res = res_q.raw;

  busy_bounded: assert property (@(posedge clk) disable iff (rst)
    $rose(int_float_busy) |-> ##[1:INT_FLOAT_CYCLES] !int_float_busy);

endmodule

// File: source/float_pkg.sv
package float_pkg;

  // Single precision layout
  localparam int FLOAT_W = 32;
  localparam int EXP_W = 8;
  localparam int MANT_W = 23;
  localparam int EXP_BIAS = 127;

  // Integer to float scan
  localparam int INT_FLOAT_CYCLES = 32;
  localparam int INT_FLOAT_CNT_W = $clog2(INT_FLOAT_CYCLES);

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [MANT_W-1:0] mant;  // Hidden bit not stored
  } float_fields_t;

  // Same word seen as raw bits or as fields
  typedef union packed {
    logic [FLOAT_W-1:0] raw;
    float_fields_t      f;
  } float_word_t;

endpackage

// File: source/alu_pkg.sv
package alu_pkg;

  typedef enum logic [3:0] {
    ALU_ADD         = 4'h0,
    ALU_SUB         = 4'h1,
    ALU_AND         = 4'h2,
    ALU_OR          = 4'h3,
    ALU_XOR         = 4'h4,
    ALU_SLL         = 4'h5,
    ALU_SRL         = 4'h6,
    ALU_SLT         = 4'h7,
    ALU_F_INT_FLOAT = 4'h8,  // Needs a start, iterative
    ALU_F_FLOAT_INT = 4'h9,
    ALU_F_ADD       = 4'ha,
    ALU_F_SUB       = 4'hb,
    ALU_F_LT        = 4'hc,
    ALU_F_LTE       = 4'hd,
    ALU_F_MUL       = 4'he,
    ALU_NOP         = 4'hf
  } alu_op_t;

endpackage
